// ==== design/ibuf_settings.svh ====
/*
  Input buffer load interface: widths and counts shared by the design
*/
`ifndef IBUF_SETTINGS_SVH
`define IBUF_SETTINGS_SVH

// Off-chip side
`define IBUF_ADDR_W      16
`define IBUF_STRIDE_W    16
`define IBUF_ITER_W      8
`define IBUF_MEM_DATA_W  32

// Buffer side
`define IBUF_DATA_W      8
`define IBUF_BANKS       8
`define IBUF_GROUP_SIZE  4
`define IBUF_NUM_GROUPS  2
`define IBUF_BUF_ADDR_W  6

// Double buffering
`define IBUF_NUM_TAGS    2
`define IBUF_TAG_W       1

`endif

// ==== design/ibuf_pkg.sv ====
/*
  Input buffer load types: vector widths, bus structs and load FSM states
*/
`default_nettype none

`include "ibuf_settings.svh"

package ibuf_pkg;

  // ==================================================
  // Vector types
  // ==================================================
  typedef logic [`IBUF_ADDR_W-1:0]                 mem_addr_t;
  typedef logic [`IBUF_STRIDE_W-1:0]               stride_t;
  typedef logic [`IBUF_ITER_W-1:0]                 iter_t;
  typedef logic [`IBUF_MEM_DATA_W-1:0]             mem_word_t;
  typedef logic [`IBUF_DATA_W-1:0]                 elem_t;
  typedef logic [`IBUF_BUF_ADDR_W-1:0]             buf_addr_t;
  typedef logic [`IBUF_TAG_W-1:0]                  tag_t;
  typedef logic [`IBUF_TAG_W+`IBUF_BUF_ADDR_W-1:0] tagged_addr_t;
  typedef logic [$clog2(`IBUF_NUM_GROUPS)-1:0]     group_idx_t;

  // ==================================================
  // Structs
  // ==================================================
  typedef struct packed {
    stride_t stride;
    iter_t   iters;
  } load_cfg_t;

  // One shared address for every bank, one element per bank
  typedef struct packed {
    logic [`IBUF_BANKS-1:0]  req;
    tagged_addr_t            addr;
    elem_t [`IBUF_BANKS-1:0] data;
  } buf_write_t;

  typedef struct packed {
    logic         req;
    tagged_addr_t addr;
  } buf_read_t;

  typedef enum logic [1:0] {
    LOAD_IDLE,
    LOAD_FETCH,
    LOAD_DRAIN,
    LOAD_DONE
  } load_state_t;

endpackage

`default_nettype wire

// ==== design/ibuf_load_ctrl.sv ====
/*
  Load control: tag bookkeeping for double buffering, the fill FSM
  and the tagged read address toward the systolic array
*/
`timescale 1ns/1ps
`default_nettype none

`include "ibuf_settings.svh"

module ibuf_load_ctrl (
  input  wire                       clk,
  input  wire                       reset,
  input  wire                       tag_req,
  input  ibuf_pkg::mem_addr_t       tag_base,
  input  wire                       cfg_v,
  input  ibuf_pkg::load_cfg_t       cfg,
  input  wire                       compute_done,
  input  wire                       buf_read_req,
  input  ibuf_pkg::buf_addr_t       buf_read_addr,
  input  wire                       last_issued,
  input  wire                       reader_idle,
  output logic                      tag_ready,
  output logic                      compute_ready,
  output ibuf_pkg::buf_read_t       buf_read,
  output logic                      walk_start,
  output ibuf_pkg::mem_addr_t       walk_base,
  output ibuf_pkg::load_cfg_t       walk_cfg,
  output logic                      load_start,
  output ibuf_pkg::tag_t            load_tag
);

  ibuf_pkg::load_state_t      state;
  ibuf_pkg::load_state_t      state_next;
  logic [`IBUF_NUM_TAGS-1:0]  tag_full;
  ibuf_pkg::tag_t             load_ptr;
  ibuf_pkg::tag_t             compute_ptr;
  ibuf_pkg::mem_addr_t        base_q;
  ibuf_pkg::load_cfg_t        cfg_q;
  logic                       start_q;
  logic                       drain_wait;
  logic                       accept;
  logic                       release_tag;

  assign tag_ready   = (state == ibuf_pkg::LOAD_IDLE) && !tag_full[load_ptr];
  assign accept      = tag_req && tag_ready;
  assign release_tag = compute_done && compute_ready;

  // ==================================================
  // Configuration and base address
  // ==================================================
  always_ff @(posedge clk) begin
    if (cfg_v) begin
      cfg_q <= cfg;
    end
    if (accept) begin
      base_q <= tag_base;
    end
  end

  // Start pulse lands in the cycle after the tag is accepted
  always_ff @(posedge clk) begin
    if (reset) begin
      start_q <= 1'b0;
    end else begin
      start_q <= accept;
    end
  end

  assign walk_start = start_q;
  assign load_start = start_q;
  assign walk_base  = base_q;
  assign walk_cfg   = cfg_q;
  assign load_tag   = load_ptr;

  // ==================================================
  // Fill FSM
  // ==================================================
  always_comb begin
    state_next = state;
    case (state)
      ibuf_pkg::LOAD_IDLE: begin
        if (accept) begin
          state_next = ibuf_pkg::LOAD_FETCH;
        end
      end
      ibuf_pkg::LOAD_FETCH: begin
        if (last_issued) begin
          state_next = ibuf_pkg::LOAD_DRAIN;
        end
      end
      // Reader back to idle, then one more cycle for the last write
      ibuf_pkg::LOAD_DRAIN: begin
        if (drain_wait) begin
          state_next = ibuf_pkg::LOAD_DONE;
        end
      end
      default: begin
        state_next = ibuf_pkg::LOAD_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= ibuf_pkg::LOAD_IDLE;
      drain_wait <= 1'b0;
    end else begin
      state      <= state_next;
      drain_wait <= (state == ibuf_pkg::LOAD_DRAIN) && reader_idle && !drain_wait;
    end
  end

  // ==================================================
  // Tag bookkeeping
  // ==================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      tag_full    <= '0;
      load_ptr    <= '0;
      compute_ptr <= '0;
    end else begin
      if (state == ibuf_pkg::LOAD_DONE) begin
        tag_full[load_ptr] <= 1'b1;
        if (load_ptr == ibuf_pkg::tag_t'(`IBUF_NUM_TAGS - 1)) begin
          load_ptr <= '0;
        end else begin
          load_ptr <= load_ptr + 1'b1;
        end
      end
      // Compute frees a full tag, never the one being filled
      if (release_tag) begin
        tag_full[compute_ptr] <= 1'b0;
        if (compute_ptr == ibuf_pkg::tag_t'(`IBUF_NUM_TAGS - 1)) begin
          compute_ptr <= '0;
        end else begin
          compute_ptr <= compute_ptr + 1'b1;
        end
      end
    end
  end

  assign compute_ready = tag_full[compute_ptr];

  // Read side sees only the tag under compute
  assign buf_read = '{req: buf_read_req, addr: {compute_ptr, buf_read_addr}};

endmodule

`default_nettype wire

// ==== design/ibuf_addr_walker.sv ====
/*
  Address walker: base plus running stride for a programmed iteration count
*/
`timescale 1ns/1ps
`default_nettype none

module ibuf_addr_walker (
  input  wire                  clk,
  input  wire                  reset,
  input  wire                  start,
  input  ibuf_pkg::mem_addr_t  base,
  input  ibuf_pkg::load_cfg_t  cfg,
  input  wire                  reader_idle,
  output ibuf_pkg::mem_addr_t  addr,
  output logic                 addr_valid,
  output logic                 last_issued
);

  ibuf_pkg::mem_addr_t  addr_q;
  ibuf_pkg::stride_t    stride_q;
  ibuf_pkg::iter_t      remaining;
  logic                 active;
  logic                 step;

  // Address is taken when the reader is free
  assign step        = active && reader_idle;
  assign last_issued = step && (remaining == ibuf_pkg::iter_t'(1));

  always_ff @(posedge clk) begin
    if (reset) begin
      active    <= 1'b0;
      remaining <= '0;
    end else if (start) begin
      active    <= 1'b1;
      remaining <= cfg.iters;
    end else if (step) begin
      remaining <= remaining - 1'b1;
      if (last_issued) begin
        active <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      addr_q   <= base;
      stride_q <= cfg.stride;
    end else if (step) begin
      addr_q <= addr_q + stride_q;
    end
  end

  assign addr       = addr_q;
  assign addr_valid = active;

endmodule

`default_nettype wire

// ==== design/ibuf_mem_reader.sv ====
/*
  Off-chip word reader over a four-phase req/ack handshake,
  one word per full handshake
*/
`timescale 1ns/1ps
`default_nettype none

module ibuf_mem_reader (
  input  wire                   clk,
  input  wire                   reset,
  input  ibuf_pkg::mem_addr_t   addr,
  input  wire                   addr_valid,
  input  wire                   mem_ack,
  input  ibuf_pkg::mem_word_t   mem_data,
  output logic                  reader_idle,
  output logic                  mem_req,
  output ibuf_pkg::mem_addr_t   mem_addr,
  output ibuf_pkg::mem_word_t   word,
  output logic                  word_valid
);

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_REQ,
    RD_RELEASE
  } rd_state_t;

  rd_state_t             state;
  ibuf_pkg::mem_addr_t   addr_q;
  ibuf_pkg::mem_word_t   data_q;
  logic                  valid_q;
  logic                  take_addr;
  logic                  take_data;

  assign reader_idle = (state == RD_IDLE);
  assign take_addr   = reader_idle && addr_valid;
  assign take_data   = (state == RD_REQ) && mem_ack;

  // ==================================================
  // Handshake FSM
  // ==================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= RD_IDLE;
      valid_q <= 1'b0;
    end else begin
      valid_q <= take_data;
      case (state)
        RD_IDLE:    if (take_addr) state <= RD_REQ;
        RD_REQ:     if (mem_ack) state <= RD_RELEASE;
        // Wait for memory to drop ack before the next request
        RD_RELEASE: if (!mem_ack) state <= RD_IDLE;
        default:    state <= RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (take_addr) begin
      addr_q <= addr;
    end
    if (take_data) begin
      data_q <= mem_data;
    end
  end

  assign mem_req    = (state == RD_REQ);
  assign mem_addr   = addr_q;
  assign word       = data_q;
  assign word_valid = valid_q;

endmodule

`default_nettype wire

// ==== design/ibuf_bank_writer.sv ====
/*
  Bank writer: replicates each fetched word across one bank group,
  rotating groups and stepping the buffer address on each wrap
*/
`timescale 1ns/1ps
`default_nettype none

`include "ibuf_settings.svh"

module ibuf_bank_writer (
  input  wire                   clk,
  input  wire                   reset,
  input  wire                   load_start,
  input  ibuf_pkg::tag_t        load_tag,
  input  ibuf_pkg::mem_word_t   word,
  input  wire                   word_valid,
  output ibuf_pkg::buf_write_t  buf_write
);

  ibuf_pkg::group_idx_t               group_idx;
  ibuf_pkg::buf_addr_t                buf_addr;
  logic [`IBUF_BANKS-1:0]             req_next;
  ibuf_pkg::elem_t [`IBUF_BANKS-1:0]  data_next;
  logic [`IBUF_BANKS-1:0]             req_q;
  ibuf_pkg::tagged_addr_t             addr_q;
  ibuf_pkg::elem_t [`IBUF_BANKS-1:0]  data_q;

  // Group rotation and buffer address
  always_ff @(posedge clk) begin
    if (reset || load_start) begin
      group_idx <= '0;
      buf_addr  <= '0;
    end else if (word_valid) begin
      if (group_idx == ibuf_pkg::group_idx_t'(`IBUF_NUM_GROUPS - 1)) begin
        group_idx <= '0;
        buf_addr  <= buf_addr + 1'b1;
      end else begin
        group_idx <= group_idx + 1'b1;
      end
    end
  end

  // Lowest element of the word goes to the lowest bank of each group
  always_comb begin
    for (int b = 0; b < `IBUF_BANKS; b++) begin
      req_next[b]  = word_valid && (group_idx == ibuf_pkg::group_idx_t'(b / `IBUF_GROUP_SIZE));
      data_next[b] = word[(b % `IBUF_GROUP_SIZE) * `IBUF_DATA_W +: `IBUF_DATA_W];
    end
  end

  // ==================================================
  // Write-out register
  // ==================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      req_q <= '0;
    end else begin
      req_q <= req_next;
    end
  end

  always_ff @(posedge clk) begin
    addr_q <= {load_tag, buf_addr};
    data_q <= data_next;
  end

  assign buf_write = '{req: req_q, addr: addr_q, data: data_q};

endmodule

`default_nettype wire

// ==== design/ibuf_top.sv ====
/*
  Input buffer load interface top: control, walker, reader and bank writer
*/
`timescale 1ns/1ps
`default_nettype none

module ibuf_top (
  input  wire                   clk,
  input  wire                   reset,
  input  wire                   tag_req,
  input  ibuf_pkg::mem_addr_t   tag_base,
  input  wire                   cfg_v,
  input  ibuf_pkg::load_cfg_t   cfg,
  input  wire                   compute_done,
  input  wire                   buf_read_req,
  input  ibuf_pkg::buf_addr_t   buf_read_addr,
  input  wire                   mem_ack,
  input  ibuf_pkg::mem_word_t   mem_data,
  output logic                  tag_ready,
  output logic                  compute_ready,
  output ibuf_pkg::buf_read_t   buf_read,
  output logic                  mem_req,
  output ibuf_pkg::mem_addr_t   mem_addr,
  output ibuf_pkg::buf_write_t  buf_write
);

  logic                  walk_start;
  ibuf_pkg::mem_addr_t   walk_base;
  ibuf_pkg::load_cfg_t   walk_cfg;
  logic                  load_start;
  ibuf_pkg::tag_t        load_tag;
  ibuf_pkg::mem_addr_t   walk_addr;
  logic                  walk_addr_valid;
  logic                  last_issued;
  logic                  reader_idle;
  ibuf_pkg::mem_word_t   word;
  logic                  word_valid;

  ibuf_load_ctrl ctrl0 (
    .clk           (clk),
    .reset         (reset),
    .tag_req       (tag_req),
    .tag_base      (tag_base),
    .cfg_v         (cfg_v),
    .cfg           (cfg),
    .compute_done  (compute_done),
    .buf_read_req  (buf_read_req),
    .buf_read_addr (buf_read_addr),
    .last_issued   (last_issued),
    .reader_idle   (reader_idle),
    .tag_ready     (tag_ready),
    .compute_ready (compute_ready),
    .buf_read      (buf_read),
    .walk_start    (walk_start),
    .walk_base     (walk_base),
    .walk_cfg      (walk_cfg),
    .load_start    (load_start),
    .load_tag      (load_tag)
  );

  ibuf_addr_walker walker0 (
    .clk         (clk),
    .reset       (reset),
    .start       (walk_start),
    .base        (walk_base),
    .cfg         (walk_cfg),
    .reader_idle (reader_idle),
    .addr        (walk_addr),
    .addr_valid  (walk_addr_valid),
    .last_issued (last_issued)
  );

  ibuf_mem_reader reader0 (
    .clk         (clk),
    .reset       (reset),
    .addr        (walk_addr),
    .addr_valid  (walk_addr_valid),
    .mem_ack     (mem_ack),
    .mem_data    (mem_data),
    .reader_idle (reader_idle),
    .mem_req     (mem_req),
    .mem_addr    (mem_addr),
    .word        (word),
    .word_valid  (word_valid)
  );

  ibuf_bank_writer writer0 (
    .clk        (clk),
    .reset      (reset),
    .load_start (load_start),
    .load_tag   (load_tag),
    .word       (word),
    .word_valid (word_valid),
    .buf_write  (buf_write)
  );

endmodule

`default_nettype wire

// ==== verification/tb_ibuf.sv ====
/*
  Testbench for the input buffer load interface: case-driven loads,
  four-phase memory model, scoreboard and watchdog
*/
`timescale 1ns/1ps
`default_nettype none

`include "ibuf_settings.svh"

module tb_ibuf;

  localparam int HALF_PERIOD = 20;
  localparam int HOLD_CYCLES = 6;

  logic                  clk = 1'b0;
  logic                  reset;
  logic                  tag_req;
  ibuf_pkg::mem_addr_t   tag_base;
  logic                  cfg_v;
  ibuf_pkg::load_cfg_t   cfg;
  logic                  compute_done;
  logic                  buf_read_req;
  ibuf_pkg::buf_addr_t   buf_read_addr;
  logic                  mem_ack;
  ibuf_pkg::mem_word_t   mem_data;
  logic                  tag_ready;
  logic                  compute_ready;
  ibuf_pkg::buf_read_t   buf_read;
  logic                  mem_req;
  ibuf_pkg::mem_addr_t   mem_addr;
  ibuf_pkg::buf_write_t  buf_write;

  // Cases from the file and the expected traffic
  ibuf_pkg::mem_addr_t   case_base[$];
  ibuf_pkg::stride_t     case_stride[$];
  ibuf_pkg::iter_t       case_iters[$];
  bit                    case_release[$];
  ibuf_pkg::mem_addr_t   exp_addr_q[$];
  ibuf_pkg::buf_write_t  exp_write_q[$];
  bit                    cases_loaded;
  bit                    reset_done;
  integer                seed = 84420;
  int                    accept_count;
  int                    release_count;
  int                    full_count;
  int                    probe_count;

  ibuf_top dut0 (
    .clk           (clk),
    .reset         (reset),
    .tag_req       (tag_req),
    .tag_base      (tag_base),
    .cfg_v         (cfg_v),
    .cfg           (cfg),
    .compute_done  (compute_done),
    .buf_read_req  (buf_read_req),
    .buf_read_addr (buf_read_addr),
    .mem_ack       (mem_ack),
    .mem_data      (mem_data),
    .tag_ready     (tag_ready),
    .compute_ready (compute_ready),
    .buf_read      (buf_read),
    .mem_req       (mem_req),
    .mem_addr      (mem_addr),
    .buf_write     (buf_write)
  );

  always #HALF_PERIOD clk = ~clk;

  // ==================================================
  // Failure handling and compare tasks
  // ==================================================
  task automatic stop_on_failure();
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_addr(input string name, input ibuf_pkg::mem_addr_t exp,
                            input ibuf_pkg::mem_addr_t act);
    if (act !== exp) begin
      $display("ERROR %0t %s expected %h actual %h", $time, name, exp, act);
      stop_on_failure();
    end
  endtask

  task automatic check_write(input string name, input ibuf_pkg::buf_write_t exp,
                             input ibuf_pkg::buf_write_t act);
    if (act !== exp) begin
      $display("ERROR %0t %s expected %h actual %h", $time, name, exp, act);
      stop_on_failure();
    end
  endtask

  task automatic check_read(input string name, input ibuf_pkg::buf_read_t exp,
                            input ibuf_pkg::buf_read_t act);
    if (act !== exp) begin
      $display("ERROR %0t %s expected %h actual %h", $time, name, exp, act);
      stop_on_failure();
    end
  endtask

  task automatic check_flag(input string name, input bit exp, input logic act);
    if (act !== exp) begin
      $display("ERROR %0t %s expected %b actual %b", $time, name, exp, act);
      stop_on_failure();
    end
  endtask

  // ==================================================
  // Reference model
  // ==================================================
  // Upper half is the address, lower half its inverse
  function automatic ibuf_pkg::mem_word_t model_word(input ibuf_pkg::mem_addr_t addr);
    return {addr, ~addr};
  endfunction

  // Write k of a load lands in group k mod 2 at buffer address k / 2
  function automatic ibuf_pkg::buf_write_t expected_write(input ibuf_pkg::tag_t tag,
                                                          input int k,
                                                          input ibuf_pkg::mem_addr_t addr);
    ibuf_pkg::buf_write_t w;
    ibuf_pkg::mem_word_t  word;
    ibuf_pkg::elem_t      elems[`IBUF_GROUP_SIZE];
    int                   group;
    word  = model_word(addr);
    group = k % `IBUF_NUM_GROUPS;
    // Peel elements off the bottom of the word, lowest first
    for (int e = 0; e < `IBUF_GROUP_SIZE; e++) begin
      elems[e] = ibuf_pkg::elem_t'(word);
      word     = word >> `IBUF_DATA_W;
    end
    w.req  = '0;
    w.addr = {tag, ibuf_pkg::buf_addr_t'(k / `IBUF_NUM_GROUPS)};
    for (int g = 0; g < `IBUF_NUM_GROUPS; g++) begin
      for (int e = 0; e < `IBUF_GROUP_SIZE; e++) begin
        w.req[g * `IBUF_GROUP_SIZE + e]  = (g == group);
        w.data[g * `IBUF_GROUP_SIZE + e] = elems[e];
      end
    end
    return w;
  endfunction

  task automatic read_cases();
    integer          fd;
    integer          code;
    logic [31:0]     base;
    logic [31:0]     stride;
    logic [31:0]     iters;
    logic [31:0]     rel;
    reg [8*160-1:0]  skip;
    fd = $fopen("verification/ibuf_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open the cases file verification/ibuf_cases.txt");
      stop_on_failure();
    end
    while (!$feof(fd)) begin
      code = $fscanf(fd, "%h %h %h %h\n", base, stride, iters, rel);
      if (code == 4) begin
        if (iters == 0 || iters > 2 * (1 << `IBUF_BUF_ADDR_W)) begin
          $display("Case %0d has an iteration count out of range", case_base.size());
          stop_on_failure();
        end
        case_base.push_back(base[15:0]);
        case_stride.push_back(stride[15:0]);
        case_iters.push_back(iters[7:0]);
        case_release.push_back(rel[0]);
      end else if (code > 0) begin
        $display("Malformed line in the cases file after case %0d", case_base.size());
        stop_on_failure();
      end else begin
        // Comment line
        code = $fgets(skip, fd);
      end
    end
    $fclose(fd);
    if (case_base.size() == 0) begin
      $display("The cases file holds no load cases");
      stop_on_failure();
    end
  endtask

  // ==================================================
  // Compute side and load sequencing
  // ==================================================
  task automatic probe_reads(input int n);
    ibuf_pkg::buf_read_t exp;
    for (int p = 0; p < n; p++) begin
      buf_read_req  = (probe_count % 3) != 0;
      buf_read_addr = ibuf_pkg::buf_addr_t'(probe_count * 13 + 5);
      probe_count++;
      #(HALF_PERIOD / 2);
      exp.req  = buf_read_req;
      exp.addr = {ibuf_pkg::tag_t'(release_count % `IBUF_NUM_TAGS), buf_read_addr};
      check_read("buf_read", exp, buf_read);
      @(negedge clk);
    end
    buf_read_req = 1'b0;
  endtask

  task automatic release_oldest();
    check_flag("compute_ready", 1'b1, compute_ready);
    compute_done = 1'b1;
    @(negedge clk);
    compute_done = 1'b0;
    release_count++;
    full_count--;
    check_flag("compute_ready", full_count > 0, compute_ready);
  endtask

  // Both tags full, so nothing may start until one is released
  task automatic hold_full();
    for (int c = 0; c < HOLD_CYCLES; c++) begin
      @(negedge clk);
      check_flag("tag_ready", 1'b0, tag_ready);
      check_flag("compute_ready", 1'b1, compute_ready);
    end
    full_count = 2;
    release_oldest();
    while (tag_ready !== 1'b1) begin
      @(negedge clk);
    end
    check_flag("compute_ready", 1'b1, compute_ready);
  endtask

  task automatic run_case(input int i);
    ibuf_pkg::tag_t       tag;
    ibuf_pkg::mem_addr_t  addr;
    while (tag_ready !== 1'b1) begin
      @(negedge clk);
    end
    tag  = ibuf_pkg::tag_t'(accept_count % `IBUF_NUM_TAGS);
    addr = case_base[i];
    for (int k = 0; k < case_iters[i]; k++) begin
      exp_addr_q.push_back(addr);
      exp_write_q.push_back(expected_write(tag, k, addr));
      addr = addr + case_stride[i];
    end
    tag_req  = 1'b1;
    tag_base = case_base[i];
    cfg_v    = 1'b1;
    cfg      = '{stride: case_stride[i], iters: case_iters[i]};
    @(negedge clk);
    tag_req  = 1'b0;
    cfg_v    = 1'b0;
    // Inputs move on once captured
    tag_base = ~case_base[i];
    cfg      = ~cfg;
    accept_count++;
    check_flag("tag_ready", 1'b0, tag_ready);
    while (exp_write_q.size() != 0) begin
      @(negedge clk);
    end
    if (full_count == 0) begin
      while (compute_ready !== 1'b1) begin
        @(negedge clk);
      end
      check_flag("tag_ready", 1'b1, tag_ready);
      full_count = 1;
    end else begin
      hold_full();
    end
    probe_reads(3);
    if (case_release[i]) begin
      release_oldest();
    end
  endtask

  // ==================================================
  // Memory model and monitors
  // ==================================================
  initial begin : memory_model
    int delay;
    mem_ack  = 1'b0;
    mem_data = '0;
    wait (reset_done);
    forever begin
      @(negedge clk);
      if (mem_req && !mem_ack) begin
        delay = {$random(seed)} % 4;
        repeat (delay) @(negedge clk);
        mem_data = model_word(mem_addr);
        mem_ack  = 1'b1;
        @(negedge clk);
        while (mem_req) begin
          @(negedge clk);
        end
        mem_ack = 1'b0;
      end
    end
  end

  initial begin : request_monitor
    logic                 req_prev;
    ibuf_pkg::mem_addr_t  held;
    req_prev = 1'b0;
    held     = '0;
    wait (reset_done);
    forever begin
      @(negedge clk);
      if (mem_req && !req_prev) begin
        if (exp_addr_q.size() == 0) begin
          $display("Off-chip read request at %0t where none was expected", $time);
          stop_on_failure();
        end
        held = exp_addr_q.pop_front();
        check_addr("mem_addr", held, mem_addr);
      end else if (mem_req) begin
        // Address must hold while the request is up
        check_addr("mem_addr", held, mem_addr);
      end
      req_prev = mem_req;
    end
  end

  initial begin : write_monitor
    ibuf_pkg::buf_write_t exp;
    wait (reset_done);
    forever begin
      @(negedge clk);
      if (|buf_write.req) begin
        if (exp_write_q.size() == 0) begin
          $display("Buffer write at %0t where none was expected", $time);
          stop_on_failure();
        end
        exp = exp_write_q.pop_front();
        check_write("buf_write", exp, buf_write);
      end
    end
  end

  initial begin : watchdog
    int max_iters;
    int limit;
    wait (cases_loaded);
    max_iters = 0;
    foreach (case_iters[i]) begin
      if (case_iters[i] > max_iters) begin
        max_iters = case_iters[i];
      end
    end
    limit = case_iters.size() * max_iters * 8 + case_iters.size() * 40 + 100;
    repeat (limit) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the DUT stopped making progress", limit);
    stop_on_failure();
  end

  // ==================================================
  // Main sequence
  // ==================================================
  initial begin : main
    reset         = 1'b1;
    tag_req       = 1'b0;
    tag_base      = '0;
    cfg_v         = 1'b0;
    cfg           = '0;
    compute_done  = 1'b0;
    buf_read_req  = 1'b0;
    buf_read_addr = '0;
    read_cases();
    cases_loaded = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    check_flag("compute_ready", 1'b0, compute_ready);
    check_flag("mem_req", 1'b0, mem_req);
    check_flag("buf_write.req", 1'b0, |buf_write.req);
    check_flag("tag_ready", 1'b1, tag_ready);
    reset_done = 1'b1;
    for (int i = 0; i < case_base.size(); i++) begin
      run_case(i);
    end
    while (full_count > 0) begin
      release_oldest();
    end
    repeat (HOLD_CYCLES) @(negedge clk);
    check_flag("tag_ready", 1'b1, tag_ready);
    if (exp_addr_q.size() != 0 || exp_write_q.size() != 0) begin
      $display("Run ended with %0d reads and %0d writes still outstanding",
               exp_addr_q.size(), exp_write_q.size());
      stop_on_failure();
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+design
design/ibuf_pkg.sv
design/ibuf_load_ctrl.sv
design/ibuf_addr_walker.sv
design/ibuf_mem_reader.sv
design/ibuf_bank_writer.sv
design/ibuf_top.sv
verification/tb_ibuf.sv

// ==== verification/ibuf_cases.txt ====
# base stride iters release, all in hex
# release 1 pulses compute_done once the load has finished
0000 0001 04 1
1000 0004 06 0
2000 0010 05 1
fff0 0008 08 1
0100 0000 03 0
0200 0002 01 0
0300 0003 07 1
abcd 0100 0c 0
4000 ffff 0a 0
5555 0005 02 1
7ffe 0001 10 1
8000 0040 09 0
9000 0020 04 0
c000 0007 0b 0
e000 1000 06 1
0042 0003 01 1
1234 0011 0d 0
f00f 0101 05 0
